// File: include/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath word width
`define CPU_XLEN 32

// program counter after reset
`define CPU_RESET_PC 32'h0000_0000

// integer register count including x0
`define CPU_NUM_REGS 32

// machine scratch and cycle counter
`define CSR_MSCRATCH 12'h340
`define CSR_MCYCLE 12'hB00

`endif

// File: source/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

  typedef logic [`CPU_XLEN-1:0] word_t;
  typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_addr_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [3:0] byte_en_t;

  // low codes follow {funct7[5], funct3}
  typedef enum logic [3:0] {
    alu_add = 4'b0000, alu_sll = 4'b0001, alu_slt = 4'b0010, alu_sltu = 4'b0011,
    alu_xor = 4'b0100, alu_srl = 4'b0101, alu_or = 4'b0110, alu_and = 4'b0111,
    alu_sub = 4'b1000, alu_sra = 4'b1101,
    alu_and_not = 4'b1110,  // csrrc
    alu_pass_b = 4'b1111
  } alu_op_t;

  typedef enum logic [2:0] {
    imm_i, imm_s, imm_b, imm_u, imm_j
  } imm_src_t;

  typedef enum logic [1:0] {
    res_alu, res_data, res_pc_target, res_pc_step
  } result_src_t;

  typedef enum logic {src_a_rd1, src_a_csr} src_a_t;

  typedef enum logic [1:0] {
    src_b_rd2, src_b_imm, src_b_rd1, src_b_rs1_index
  } src_b_t;

  typedef enum logic [2:0] {
    br_none, br_cond, br_jal, br_jalr, br_halt
  } branch_type_t;

endpackage

// File: source/cpu_control.sv
`timescale 1ns/1ps

module cpu_control import cpu_pkg::*; (
  input  logic [6:0]   op,
  input  logic [2:0]   funct3,
  input  logic         funct7_5,
  output imm_src_t     imm_src,
  output src_a_t       src_a,
  output src_b_t       src_b,
  output alu_op_t      alu_op,
  output result_src_t  result_src,
  output branch_type_t branch_type,
  output byte_en_t     store_en,
  output logic         reg_write,
  output logic         csr_write,
  output logic         wb_from_csr
);

  always_comb begin
    imm_src     = imm_i;
    src_a       = src_a_rd1;
    src_b       = src_b_rd2;
    alu_op      = alu_add;
    result_src  = res_alu;
    branch_type = br_none;
    store_en    = 4'b0000;
    reg_write   = 1'b0;
    csr_write   = 1'b0;
    wb_from_csr = 1'b0;

    case (op)
      7'b0000011: begin  // loads
        src_b      = src_b_imm;
        result_src = res_data;
        reg_write  = 1'b1;
      end
      7'b0100011: begin  // stores
        imm_src = imm_s;
        src_b   = src_b_imm;
        case (funct3)
          3'b000:  store_en = 4'b0001;
          3'b001:  store_en = 4'b0011;
          3'b010:  store_en = 4'b1111;
          default: store_en = 4'b0000;
        endcase
      end
      7'b0010011: begin  // op-imm where bit 30 only matters for right shifts
        src_b     = src_b_imm;
        alu_op    = alu_op_t'({(funct3 == 3'b101) ? funct7_5 : 1'b0, funct3});
        reg_write = 1'b1;
      end
      7'b0110011: begin
        alu_op    = alu_op_t'({funct7_5, funct3});
        reg_write = 1'b1;
      end
      7'b0110111: begin  // lui
        imm_src   = imm_u;
        src_b     = src_b_imm;
        alu_op    = alu_pass_b;
        reg_write = 1'b1;
      end
      7'b0010111: begin  // auipc
        imm_src    = imm_u;
        result_src = res_pc_target;
        reg_write  = 1'b1;
      end
      7'b1100011: begin
        imm_src     = imm_b;
        alu_op      = alu_sub;  // flags drive the compare
        branch_type = br_cond;
      end
      7'b1101111: begin  // jal
        imm_src     = imm_j;
        branch_type = br_jal;
        result_src  = res_pc_step;
        reg_write   = 1'b1;
      end
      7'b1100111: begin  // jalr
        src_b       = src_b_imm;
        branch_type = br_jalr;
        result_src  = res_pc_step;
        reg_write   = 1'b1;
      end
      7'b1110011: begin
        if (funct3[1:0] == 2'b00) begin
          branch_type = br_halt;  // ecall, ebreak, mret
        end else begin
          src_a       = src_a_csr;
          src_b       = funct3[2] ? src_b_rs1_index : src_b_rd1;
          case (funct3[1:0])
            2'b01:   alu_op = alu_pass_b;
            2'b10:   alu_op = alu_or;
            default: alu_op = alu_and_not;
          endcase
          reg_write   = 1'b1;
          csr_write   = 1'b1;
          wb_from_csr = 1'b1;  // rd gets the old csr value
        end
      end
      default: branch_type = br_halt;
    endcase
  end

endmodule

// File: source/cpu_imm_extend.sv
`timescale 1ns/1ps

module cpu_imm_extend import cpu_pkg::*; (
  input  word_t    instr,
  input  imm_src_t imm_src,
  output word_t    imm
);

  always_comb begin
    case (imm_src)
      imm_i: imm = {{20{instr[31]}}, instr[31:20]};
      imm_s: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      imm_b: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      imm_u: imm = {instr[31:12], 12'b0};
      imm_j: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

endmodule

// File: source/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
  input  word_t   src_a,
  input  word_t   src_b,
  input  alu_op_t alu_op,
  output word_t   result,
  output logic    zero,
  output logic    lt,
  output logic    borrow
);

  word_t diff;
  logic [4:0] shamt;

  assign {borrow, diff} = {1'b0, src_a} - {1'b0, src_b};
  assign zero  = (diff == '0);
  // with differing signs a is less exactly when it is negative
  assign lt    = (src_a[31] != src_b[31]) ? src_a[31] : diff[31];
  assign shamt = src_b[4:0];

  always_comb begin
    case (alu_op)
      alu_add:     result = src_a + src_b;
      alu_sub:     result = diff;
      alu_sll:     result = src_a << shamt;
      alu_srl:     result = src_a >> shamt;
      alu_sra:     result = word_t'($signed(src_a) >>> shamt);
      alu_slt:     result = word_t'(lt);
      alu_sltu:    result = word_t'(borrow);
      alu_xor:     result = src_a ^ src_b;
      alu_or:      result = src_a | src_b;
      alu_and:     result = src_a & src_b;
      alu_and_not: result = src_a & ~src_b;
      alu_pass_b:  result = src_b;
      default:     result = '0;
    endcase
  end

endmodule

// File: source/cpu_register_file.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_register_file import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t a1,
  input  reg_addr_t a2,
  input  reg_addr_t a3,
  input  logic      we,
  input  word_t     wd,
  output word_t     rd1,
  output word_t     rd2
);

  word_t regs [`CPU_NUM_REGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) regs[i] <= '0;
    end else if (we && a3 != '0) begin
      regs[a3] <= wd;
    end
  end

  assign rd1 = (a1 == '0) ? '0 : regs[a1];  // x0 hardwired
  assign rd2 = (a2 == '0) ? '0 : regs[a2];

endmodule

// File: source/cpu_csr_file.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_csr_file import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  csr_addr_t addr,
  input  word_t     wdata,
  input  logic      we,
  output word_t     rdata
);

  word_t mscratch;
  word_t mcycle;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mscratch <= '0;
    end else if (we && addr == `CSR_MSCRATCH) begin
      mscratch <= wdata;
    end
  end

  // free running and ignores writes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcycle <= '0;
    end else begin
      mcycle <= mcycle + 1;
    end
  end

  always_comb begin
    case (addr)
      `CSR_MSCRATCH: rdata = mscratch;
      `CSR_MCYCLE:   rdata = mcycle;  // pre-increment value
      default:       rdata = '0;
    endcase
  end

endmodule

// File: source/single_cycle_cpu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module single_cycle_cpu import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  output word_t    instr_addr,
  input  word_t    instr_data,
  output word_t    data_addr,
  output word_t    data_wdata,
  output byte_en_t data_wenable,
  input  word_t    data_rdata
);

  word_t pc, pc_next, pc_step, pc_target;
  word_t imm, rd1, rd2, csr_rdata;
  word_t alu_a, alu_b, alu_result, result, load_word, load_ext, reg_wd;
  logic  alu_zero, alu_lt, alu_borrow, take_branch;

  imm_src_t     imm_src;
  src_a_t       src_a;
  src_b_t       src_b;
  alu_op_t      alu_op;
  result_src_t  result_src;
  branch_type_t branch_type;
  byte_en_t     store_en;
  logic         reg_write, csr_write, wb_from_csr;

  logic [2:0] funct3;
  reg_addr_t  rs1;
  logic [1:0] byte_off;

  assign funct3   = instr_data[14:12];
  assign rs1      = instr_data[19:15];
  assign byte_off = alu_result[1:0];

  cpu_control u_control (
    .op(instr_data[6:0]), .funct3(funct3), .funct7_5(instr_data[30]),
    .imm_src(imm_src), .src_a(src_a), .src_b(src_b), .alu_op(alu_op),
    .result_src(result_src), .branch_type(branch_type), .store_en(store_en),
    .reg_write(reg_write), .csr_write(csr_write), .wb_from_csr(wb_from_csr)
  );

  cpu_imm_extend u_imm_extend (.instr(instr_data), .imm_src(imm_src), .imm(imm));

  cpu_register_file u_register_file (
    .clk(clk), .rst_n(rst_n), .a1(rs1), .a2(instr_data[24:20]), .a3(instr_data[11:7]),
    .we(reg_write & rst_n), .wd(reg_wd), .rd1(rd1), .rd2(rd2)
  );

  cpu_csr_file u_csr_file (
    .clk(clk), .rst_n(rst_n), .addr(instr_data[31:20]), .wdata(alu_result),
    .we(csr_write & rst_n), .rdata(csr_rdata)
  );

  assign alu_a = (src_a == src_a_csr) ? csr_rdata : rd1;

  always_comb begin
    case (src_b)
      src_b_imm:       alu_b = imm;
      src_b_rd1:       alu_b = rd1;
      src_b_rs1_index: alu_b = word_t'(rs1);  // csr uimm forms
      default:         alu_b = rd2;
    endcase
  end

  cpu_alu u_alu (
    .src_a(alu_a), .src_b(alu_b), .alu_op(alu_op), .result(alu_result),
    .zero(alu_zero), .lt(alu_lt), .borrow(alu_borrow)
  );

  // store lanes move up to the addressed byte
  assign data_addr    = alu_result;
  assign data_wdata   = rd2 << {byte_off, 3'b000};
  assign data_wenable = rst_n ? byte_en_t'(store_en << byte_off) : 4'b0000;

  assign load_word = data_rdata >> {byte_off, 3'b000};

  always_comb begin
    case (funct3)
      3'b000:  load_ext = {{24{load_word[7]}}, load_word[7:0]};   // lb
      3'b001:  load_ext = {{16{load_word[15]}}, load_word[15:0]}; // lh
      3'b100:  load_ext = {24'b0, load_word[7:0]};
      3'b101:  load_ext = {16'b0, load_word[15:0]};
      default: load_ext = load_word;
    endcase
  end

  assign pc_step   = pc + 32'd4;
  assign pc_target = pc + imm;

  always_comb begin
    case (result_src)
      res_data:      result = load_ext;
      res_pc_target: result = pc_target;
      res_pc_step:   result = pc_step;
      default:       result = alu_result;
    endcase
  end

  assign reg_wd = wb_from_csr ? csr_rdata : result;

  always_comb begin
    case (funct3)
      3'b000:  take_branch = alu_zero;
      3'b001:  take_branch = !alu_zero;
      3'b100:  take_branch = alu_lt;
      3'b101:  take_branch = !alu_lt;
      3'b110:  take_branch = alu_borrow;  // unsigned
      3'b111:  take_branch = !alu_borrow;
      default: take_branch = 1'b0;
    endcase
  end

  always_comb begin
    case (branch_type)
      br_cond: pc_next = take_branch ? pc_target : pc_step;
      br_jal:  pc_next = pc_target;
      br_jalr: pc_next = {alu_result[31:1], 1'b0};
      br_halt: pc_next = pc;  // spin until reset
      default: pc_next = pc_step;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `CPU_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assign instr_addr = pc;

endmodule

// File: test/tb_single_cycle_cpu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_single_cycle_cpu;

  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_system = 7'b1110011;

  logic clk, rst_n;
  logic [31:0] instr_addr, instr_data, data_addr, data_wdata, data_rdata;
  logic [3:0] data_wenable;

  logic [31:0] rom [256];
  logic [31:0] ram [256];
  logic [31:0] ram_init [256];
  logic [31:0] exp_addr [256];
  logic [31:0] exp_data [256];
  string exp_name [256];
  int exp_count = 0;
  int n_instr = 0;
  int slot = 0;
  int store_idx;
  integer seed = 32'h2f074a38;
  logic [31:0] a, b, halt_pc, store_word, want_addr, want_data;

  single_cycle_cpu dut (
    .clk(clk), .rst_n(rst_n), .instr_addr(instr_addr), .instr_data(instr_data),
    .data_addr(data_addr), .data_wdata(data_wdata), .data_wenable(data_wenable),
    .data_rdata(data_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  assign instr_data = rom[instr_addr[9:2]];
  assign data_rdata = ram[data_addr[9:2]];

  always @(posedge clk) begin
    if (!rst_n) begin
      ram <= ram_init;  // reload while the core is held
      store_idx <= 0;
    end else if (data_wenable != 4'b0000) begin
      ram[data_addr[9:2]] <= store_word;
      store_idx <= store_idx + 1;
    end
  end

  // word as it will look after this edge
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      store_word[8*i +: 8] = data_wenable[i] ? data_wdata[8*i +: 8]
                                             : ram[data_addr[9:2]][8*i +: 8];
    end
    want_addr = exp_addr[store_idx[7:0]];
    want_data = exp_data[store_idx[7:0]];
  end

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
    fail_run($sformatf("[ERROR] %s: expected %h, actual %h", name, want, got));
  endtask

  assert property (@(negedge clk) disable iff (!rst_n)
      data_wenable != 4'b0000 |-> store_idx < exp_count)
    else fail_run("the program made more stores than expected");
  assert property (@(negedge clk) disable iff (!rst_n)
      data_wenable != 4'b0000 |-> {data_addr[31:2], 2'b00} == want_addr)
    else report_mismatch({exp_name[store_idx[7:0]], " address"}, want_addr,
                         {data_addr[31:2], 2'b00});
  assert property (@(negedge clk) disable iff (!rst_n)
      data_wenable != 4'b0000 |-> store_word == want_data)
    else report_mismatch(exp_name[store_idx[7:0]], want_data, store_word);
  assert property (@(negedge clk) disable iff (!rst_n) instr_addr[1:0] == 2'b00)
    else fail_run("instruction fetch from an address that is not word aligned");

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                        input logic [31:0] y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      3'b111:  return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  task automatic emit(input logic [31:0] instr);
    rom[n_instr] = instr;
    n_instr++;
  endtask

  task automatic expect_word(input string name, input logic [31:0] addr,
                             input logic [31:0] want);
    exp_name[exp_count] = name;
    exp_addr[exp_count] = addr;
    exp_data[exp_count] = want;
    exp_count++;
  endtask

  // sw into the next result word above x10
  task automatic store_slot(input string name, input logic [4:0] rs2, input logic [31:0] want);
    emit(s_type(12'(slot * 4), rs2, 5'd10, 3'b010));
    expect_word(name, 32'h100 + 32'(slot * 4), want);
    slot++;
  endtask

  task automatic reg_op(input string name, input logic [6:0] f7, input logic [2:0] f3,
                        input logic [31:0] want);
    emit(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
    store_slot(name, 5'd3, want);
  endtask

  task automatic imm_op(input string name, input logic [11:0] imm, input logic [2:0] f3,
                        input logic [31:0] want);
    emit(i_type(imm, 5'd1, f3, 5'd3, op_imm));
    store_slot(name, 5'd3, want);
  endtask

  task automatic load_check(input string name, input logic [2:0] f3, input int off,
                            input logic [31:0] want);
    emit(i_type(12'(off), 5'd11, f3, 5'd3, op_load));
    store_slot($sformatf("%s offset %0d", name, off), 5'd3, want);
  endtask

  // marker 1 when taken and 2 when the fall-through addi runs
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] r1, input logic [4:0] r2,
                             input logic [31:0] v1, input logic [31:0] v2);
    emit(i_type(12'd1, 5'd0, 3'b000, 5'd5, op_imm));
    emit(b_type(13'd8, r2, r1, f3));
    emit(i_type(12'd2, 5'd0, 3'b000, 5'd5, op_imm));
    store_slot($sformatf("branch funct3 %0d x%0d x%0d", f3, r1, r2), 5'd5,
               branch_taken(f3, v1, v2) ? 32'd1 : 32'd2);
  endtask

  task automatic csr_op(input string name, input logic [2:0] f3, input logic [4:0] src,
                        input logic [31:0] old_value);
    emit(i_type(`CSR_MSCRATCH, src, f3, 5'd3, op_system));
    store_slot(name, 5'd3, old_value);
  endtask

  task automatic build_program();
    logic [31:0] si, w, pc_mark, ms;
    logic [2:0] f3s [6];
    si = {{20{1'b1}}, 12'h9c5};
    w = ram_init[2];
    f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    emit(i_type(12'd0, 5'd0, 3'b010, 5'd1, op_load));
    emit(i_type(12'd4, 5'd0, 3'b010, 5'd2, op_load));
    emit(i_type(12'h100, 5'd0, 3'b000, 5'd10, op_imm));  // result area
    emit(i_type(12'd8, 5'd0, 3'b000, 5'd11, op_imm));
    emit(i_type(12'hffb, 5'd0, 3'b000, 5'd6, op_imm));
    emit(i_type(12'd3, 5'd0, 3'b000, 5'd7, op_imm));
    reg_op("add", 7'h00, 3'd0, a + b);
    reg_op("sub", 7'h20, 3'd0, a - b);
    reg_op("sll", 7'h00, 3'd1, a << b[4:0]);
    reg_op("slt", 7'h00, 3'd2, {31'b0, $signed(a) < $signed(b)});
    reg_op("sltu", 7'h00, 3'd3, {31'b0, a < b});
    reg_op("xor", 7'h00, 3'd4, a ^ b);
    reg_op("srl", 7'h00, 3'd5, a >> b[4:0]);
    reg_op("sra", 7'h20, 3'd5, $signed(a) >>> b[4:0]);
    reg_op("or", 7'h00, 3'd6, a | b);
    reg_op("and", 7'h00, 3'd7, a & b);
    emit(r_type(7'h00, 5'd1, 5'd2, 3'd2, 5'd3));
    store_slot("slt swapped", 5'd3, {31'b0, $signed(b) < $signed(a)});
    imm_op("addi", 12'h9c5, 3'd0, a + si);
    imm_op("slti", 12'h9c5, 3'd2, {31'b0, $signed(a) < $signed(si)});
    imm_op("sltiu", 12'h9c5, 3'd3, {31'b0, a < si});
    imm_op("xori", 12'h9c5, 3'd4, a ^ si);
    imm_op("ori", 12'h9c5, 3'd6, a | si);
    imm_op("andi", 12'h9c5, 3'd7, a & si);
    imm_op("slli", 12'h007, 3'd1, a << 7);
    imm_op("srli", 12'h009, 3'd5, a >> 9);
    imm_op("srai", 12'h409, 3'd5, $signed(a) >>> 9);
    for (int o = 0; o < 4; o++) begin
      load_check("lb", 3'b000, o, {{24{w[8*o+7]}}, w[8*o +: 8]});
      load_check("lbu", 3'b100, o, {24'b0, w[8*o +: 8]});
      if (o % 2 == 0) begin
        load_check("lh", 3'b001, o, {{16{w[8*o+15]}}, w[8*o +: 16]});
        load_check("lhu", 3'b101, o, {16'b0, w[8*o +: 16]});
      end
    end
    load_check("lw", 3'b010, 0, w);
    emit(s_type(12'd5, 5'd1, 5'd11, 3'b000));
    expect_word("sb offset 1", 32'd12, {ram_init[3][31:16], a[7:0], ram_init[3][7:0]});
    emit(s_type(12'd11, 5'd1, 5'd11, 3'b000));
    expect_word("sb offset 3", 32'd16, {a[7:0], ram_init[4][23:0]});
    emit(s_type(12'd14, 5'd1, 5'd11, 3'b001));
    expect_word("sh offset 2", 32'd20, {a[15:0], ram_init[5][15:0]});
    emit(s_type(12'd16, 5'd1, 5'd11, 3'b001));
    expect_word("sh offset 0", 32'd24, {ram_init[6][31:16], a[15:0]});
    for (int k = 0; k < 6; k++) begin
      branch_case(f3s[k], 5'd1, 5'd1, a, a);
      branch_case(f3s[k], 5'd6, 5'd7, 32'hffff_fffb, 32'd3);
      branch_case(f3s[k], 5'd7, 5'd6, 32'd3, 32'hffff_fffb);
    end
    pc_mark = 32'(n_instr * 4);
    emit(j_type(21'd8, 5'd5));
    emit(i_type(12'd99, 5'd0, 3'b000, 5'd5, op_imm));  // skipped
    store_slot("jal link", 5'd5, pc_mark + 32'd4);
    pc_mark = 32'(n_instr * 4);
    emit(u_type(20'h0, 5'd8, op_auipc));
    emit(i_type(12'd13, 5'd8, 3'b000, 5'd5, op_jalr));  // odd target
    emit(i_type(12'd99, 5'd0, 3'b000, 5'd5, op_imm));
    store_slot("jalr link", 5'd5, pc_mark + 32'd8);
    emit(u_type(20'habcde, 5'd3, op_lui));
    store_slot("lui", 5'd3, 32'habcde000);
    pc_mark = 32'(n_instr * 4);
    emit(u_type(20'h12345, 5'd3, op_auipc));
    store_slot("auipc", 5'd3, pc_mark + 32'h12345000);
    ms = 32'd0;
    csr_op("csrrw", 3'b001, 5'd1, ms);
    ms = a;
    csr_op("csrrs", 3'b010, 5'd2, ms);
    ms = ms | b;
    csr_op("csrrc", 3'b011, 5'd1, ms);
    ms = ms & ~a;
    csr_op("csrrwi", 3'b101, 5'd21, ms);
    ms = 32'd21;
    csr_op("csrrsi", 3'b110, 5'd10, ms);
    ms = ms | 32'd10;
    csr_op("csrrci", 3'b111, 5'd5, ms);
    ms = ms & ~32'd5;
    csr_op("mscratch final", 3'b010, 5'd0, ms);
    emit(i_type(`CSR_MCYCLE, 5'd0, 3'b010, 5'd3, op_system));
    repeat (4) emit(i_type(12'd0, 5'd0, 3'b000, 5'd0, op_imm));
    emit(i_type(`CSR_MCYCLE, 5'd0, 3'b010, 5'd4, op_system));
    emit(r_type(7'h20, 5'd3, 5'd4, 3'd0, 5'd4));
    store_slot("mcycle delta", 5'd4, 32'd5);
    halt_pc = 32'(n_instr * 4);
    emit(32'h0000_000b);  // custom-0 is undefined here
  endtask

  initial begin
    int cycles;
    rst_n = 1'b0;
    for (int i = 0; i < 256; i++) begin
      ram_init[i] = $random(seed);
      rom[i] = {17'b0, 8'(i), 7'b0001011};
    end
    ram_init[0][31] = 1'b1;  // negative so srai and srli differ
    a = ram_init[0];
    b = ram_init[1];
    build_program();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    cycles = 0;
    while (instr_addr != halt_pc && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (instr_addr != halt_pc) begin
      fail_run("the program never halted within 2000 cycles");
    end
    repeat (20) begin
      @(negedge clk);
      assert (instr_addr == halt_pc) else report_mismatch("halt pc", halt_pc, instr_addr);
      assert (data_wenable == 4'b0000)
        else report_mismatch("halt store enable", 32'd0, 32'(data_wenable));
    end
    if (store_idx != exp_count) begin
      report_mismatch("store count", 32'(exp_count), 32'(store_idx));
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// File: sources.f
+incdir+include
source/cpu_pkg.sv
source/cpu_control.sv
source/cpu_imm_extend.sv
source/cpu_alu.sv
source/cpu_register_file.sv
source/cpu_csr_file.sv
source/single_cycle_cpu.sv
test/tb_single_cycle_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_single_cycle_cpu
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= run.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST OK" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
